//--- sources.f
hw/core_types_pkg.sv
hw/mem_bus_pkg.sv
hw/fetch_pc_unit.sv
hw/lsu_req_buffer.sv
hw/mem_request_arbiter.sv
hw/bus_response_router.sv
hw/mem_request_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f sources.f
./obj_dir/Vtb_top > sim.log 2>&1 || true
cat sim.log
if grep -qx "Testbench passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

//--- dv/tb_top.sv
`default_nettype none

module tb_top
    import core_types_pkg::*, mem_bus_pkg::*;
();

    localparam addr_t TB_RESET_PC = 32'h0000_0200;

    logic        clk;
    logic        rst;
    redir_kind_e i_redir_kind;
    addr_t       i_redir_pc;
    addr_t       i_redir_base;
    addr_t       i_redir_imm;
    logic        i_dreq_valid;
    logic        o_dreq_ready;
    logic        i_dreq_we;
    addr_t       i_dreq_addr;
    word_t       i_dreq_wdata;
    logic        o_instr_valid;
    logic        i_instr_ready;
    instr_t      o_instr;
    addr_t       o_instr_pc;
    logic        o_ld_valid;
    word_t       o_ld_data;
    logic        o_freeze;
    logic        o_bus_valid;
    logic        i_bus_ready;
    logic        o_bus_we;
    addr_t       o_bus_addr;
    word_t       o_bus_wdata;
    logic        i_bus_rvalid;
    word_t       i_bus_rdata;
    int          checks;
    int          errors;
    int          last_checks;
    int          last_errors;
    logic        ready_random;
    word_t       mem [addr_t];

    mem_request_top #(
        .P_RESET_PC(TB_RESET_PC)
    ) i_dut (.*);

    tb_checker #(
        .P_RESET_PC(TB_RESET_PC)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .i_redir_kind (i_redir_kind),
        .i_redir_pc   (i_redir_pc),
        .i_redir_base (i_redir_base),
        .i_redir_imm  (i_redir_imm),
        .i_dreq_valid (i_dreq_valid),
        .i_dreq_ready (o_dreq_ready),
        .i_dreq_we    (i_dreq_we),
        .i_dreq_addr  (i_dreq_addr),
        .i_dreq_wdata (i_dreq_wdata),
        .i_instr_valid(o_instr_valid),
        .i_instr_ready(i_instr_ready),
        .i_instr      (o_instr),
        .i_instr_pc   (o_instr_pc),
        .i_ld_valid   (o_ld_valid),
        .i_ld_data    (o_ld_data),
        .i_freeze     (o_freeze),
        .i_bus_valid  (o_bus_valid),
        .i_bus_ready  (i_bus_ready),
        .i_bus_we     (o_bus_we),
        .i_bus_rvalid (i_bus_rvalid),
        .o_checks     (checks),
        .o_errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic word_t bus_word(input addr_t addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    // bus slave with random stalls and a response latency of 1 to 6 cycles
    initial begin : bus_model
        int unsigned latency;
        logic        req_we;
        addr_t       req_addr;
        i_bus_ready  = 1'b0;
        i_bus_rvalid = 1'b0;
        i_bus_rdata  = '0;
        forever begin
            @(negedge clk);
            i_bus_rvalid = 1'b0;
            i_bus_ready  = ($urandom_range(0, 3) != 0);
            @(posedge clk);
            if (!rst && o_bus_valid && i_bus_ready) begin
                req_we   = o_bus_we;
                req_addr = o_bus_addr;
                if (req_we) begin
                    mem[req_addr] = o_bus_wdata;
                end
                latency = $urandom_range(6, 1);
                repeat (latency) begin
                    @(negedge clk);
                end
                i_bus_ready  = 1'b0;
                i_bus_rvalid = 1'b1;
                i_bus_rdata  = req_we ? 32'h0 : bus_word(req_addr);
            end
        end
    end

    // decode back-pressure in random spans once enabled
    initial begin : instr_ready_drive
        int unsigned span;
        span          = 0;
        i_instr_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (!ready_random) begin
                i_instr_ready = 1'b1;
            end else if (span == 0) begin
                i_instr_ready = ($urandom_range(0, 1) == 1);
                span          = $urandom_range(5, 1);
            end else begin
                span = span - 1;
            end
        end
    end

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_instrs(input int n, input string what);
        int got;
        int cycles;
        got    = 0;
        cycles = 0;
        while (got < n) begin
            @(posedge clk);
            if (o_instr_valid && i_instr_ready) begin
                got++;
            end
            cycles++;
            if (cycles > n * 200) begin
                timeout_fail(what);
            end
        end
    endtask

    task automatic apply_redirect(input redir_kind_e kind, input addr_t pc,
                                  input addr_t base, input addr_t imm);
        @(negedge clk);
        i_redir_kind = kind;
        i_redir_pc   = pc;
        i_redir_base = base;
        i_redir_imm  = imm;
        @(negedge clk);
        i_redir_kind = NONE;
    endtask

    task automatic data_access(input logic we, input addr_t addr, input word_t wdata);
        int cycles;
        cycles = 0;
        @(negedge clk);
        i_dreq_valid = 1'b1;
        i_dreq_we    = we;
        i_dreq_addr  = addr;
        i_dreq_wdata = wdata;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                timeout_fail("data request acceptance");
            end
        end while (!o_dreq_ready);
        @(negedge clk);
        i_dreq_valid = 1'b0;
        cycles       = 0;
        while (o_freeze) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) begin
                timeout_fail("freeze to fall after a data access");
            end
        end
    endtask

    task automatic random_access();
        addr_t addr;
        logic  we;
        addr = 32'h0010_0000 + 4 * $urandom_range(0, 15);
        we   = ($urandom_range(0, 1) == 1);
        data_access(we, addr, $urandom());
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d checks, %0d errors", name,
                 checks - last_checks, errors - last_errors);
        last_checks = checks;
        last_errors = errors;
    endtask

    initial begin : main_sequence
        void'($urandom(32'h372d_1abf));
        rst          = 1'b1;
        ready_random = 1'b0;
        i_redir_kind = NONE;
        i_redir_pc   = '0;
        i_redir_base = '0;
        i_redir_imm  = '0;
        i_dreq_valid = 1'b0;
        i_dreq_we    = 1'b0;
        i_dreq_addr  = '0;
        i_dreq_wdata = '0;
        last_checks  = 0;
        last_errors  = 0;
        repeat (8) begin
            @(negedge clk);
        end
        rst = 1'b0;

        wait_instrs(8, "instructions after reset");
        end_test("reset_sequence");

        apply_redirect(BRANCH, 32'h0000_0300, 32'h0, 32'h0000_0040);
        wait_instrs(3, "instructions after branch");
        apply_redirect(JAL, 32'h0000_0400, 32'h0, 32'hFFFF_FF80);
        wait_instrs(3, "instructions after jal");
        apply_redirect(JALR, 32'h0, 32'h0000_0501, 32'h0000_0010);
        wait_instrs(3, "instructions after jalr");
        end_test("redirects");

        data_access(1'b1, 32'h0010_0040, 32'hDEAD_BEEF);
        data_access(1'b0, 32'h0010_0040, 32'h0);
        data_access(1'b0, 32'h0010_0080, 32'h0);
        end_test("store_load");

        // data must still get through while decode holds an instruction
        ready_random = 1'b1;
        repeat (4) begin
            random_access();
        end
        end_test("freeze_window");

        repeat (6) begin
            wait_instrs(10, "instructions under back-pressure");
            random_access();
        end
        end_test("backpressure");

        $display("all tests done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`default_nettype none

module tb_checker
    import core_types_pkg::*, mem_bus_pkg::*;
#(
    parameter addr_t P_RESET_PC = RESET_PC
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire redir_kind_e i_redir_kind,
    input  wire addr_t       i_redir_pc,
    input  wire addr_t       i_redir_base,
    input  wire addr_t       i_redir_imm,
    input  wire logic        i_dreq_valid,
    input  wire logic        i_dreq_ready,
    input  wire logic        i_dreq_we,
    input  wire addr_t       i_dreq_addr,
    input  wire word_t       i_dreq_wdata,
    input  wire logic        i_instr_valid,
    input  wire logic        i_instr_ready,
    input  wire instr_t      i_instr,
    input  wire addr_t       i_instr_pc,
    input  wire logic        i_ld_valid,
    input  wire word_t       i_ld_data,
    input  wire logic        i_freeze,
    input  wire logic        i_bus_valid,
    input  wire logic        i_bus_ready,
    input  wire logic        i_bus_we,
    input  wire logic        i_bus_rvalid,
    output int               o_checks,
    output int               o_errors
);

    addr_t  exp_pc;
    logic   held;
    instr_t held_instr;
    addr_t  held_pc;
    logic   bus_store;
    logic   store_tail;
    int     stores_open;
    word_t  shadow [addr_t];
    word_t  ld_queue [$];

    // memory content before any store touched it
    function automatic word_t mem_init(input addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    function automatic addr_t redir_target(input redir_kind_e kind, input addr_t pc,
                                           input addr_t base, input addr_t imm);
        addr_t sum;
        if (kind == JALR) begin
            sum    = base + imm;
            sum[0] = 1'b0;
            return sum;
        end
        return pc + imm;
    endfunction

    function automatic word_t expected_load(input addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return mem_init(addr);
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t expected);
        o_checks = o_checks + 1;
        if (got !== expected) begin
            o_errors = o_errors + 1;
            $display("FAIL %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic report_error(input string msg);
        o_errors = o_errors + 1;
        $display("ERROR %s", msg);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_pc      = P_RESET_PC;
            held        = 1'b0;
            bus_store   = 1'b0;
            store_tail  = 1'b0;
            stores_open = 0;
            o_checks    = 0;
            o_errors    = 0;
            ld_queue.delete();
            shadow.delete();
        end else begin
            // a held instruction only leaves through a transfer or a redirect
            if (held && i_instr_valid) begin
                compare_word("o_instr", i_instr, held_instr);
                compare_word("o_instr_pc", i_instr_pc, held_pc);
            end
            if (i_instr_valid && i_instr_ready) begin
                compare_word("o_instr_pc", i_instr_pc, exp_pc);
                compare_word("o_instr", i_instr, mem_init(exp_pc));
                exp_pc = exp_pc + 32'd4;
            end
            held       = i_instr_valid && !i_instr_ready;
            held_instr = i_instr;
            held_pc    = i_instr_pc;
            // transfers on the redirect edge still belong to the old path
            if (i_redir_kind != NONE) begin
                exp_pc = redir_target(i_redir_kind, i_redir_pc, i_redir_base, i_redir_imm);
            end
            if (i_dreq_valid) begin
                compare_word("o_freeze", word_t'(i_freeze), 32'd1);
            end
            if (i_dreq_valid && i_dreq_ready) begin
                if (i_dreq_we) begin
                    shadow[i_dreq_addr] = i_dreq_wdata;
                    stores_open         = stores_open + 1;
                end else begin
                    ld_queue.push_back(expected_load(i_dreq_addr));
                end
            end
            // freeze lasts up to and including the cycle after the response
            if (!i_freeze && (ld_queue.size() != 0 || stores_open != 0)) begin
                report_error("freeze went low while a data access was still outstanding");
            end
            if (i_ld_valid) begin
                if (ld_queue.size() == 0) begin
                    report_error("load data pulse arrived with no load outstanding");
                end else begin
                    compare_word("o_ld_data", i_ld_data, ld_queue.pop_front());
                end
            end
            if (store_tail) begin
                stores_open = stores_open - 1;
            end
            store_tail = i_bus_rvalid && bus_store;
            if (i_bus_valid && i_bus_ready) begin
                bus_store = i_bus_we;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_request_top.sv
`default_nettype none

module mem_request_top
    import core_types_pkg::*, mem_bus_pkg::*;
#(
    parameter addr_t P_RESET_PC = RESET_PC
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire redir_kind_e i_redir_kind,
    input  wire addr_t       i_redir_pc,
    input  wire addr_t       i_redir_base,
    input  wire addr_t       i_redir_imm,
    input  wire logic        i_dreq_valid,
    output logic             o_dreq_ready,
    input  wire logic        i_dreq_we,
    input  wire addr_t       i_dreq_addr,
    input  wire word_t       i_dreq_wdata,
    output logic             o_instr_valid,
    input  wire logic        i_instr_ready,
    output instr_t           o_instr,
    output addr_t            o_instr_pc,
    output logic             o_ld_valid,
    output word_t            o_ld_data,
    output logic             o_freeze,
    output logic             o_bus_valid,
    input  wire logic        i_bus_ready,
    output logic             o_bus_we,
    output addr_t            o_bus_addr,
    output word_t            o_bus_wdata,
    input  wire logic        i_bus_rvalid,
    input  wire word_t       i_bus_rdata
);

    logic     fetch_valid;
    logic     fetch_ready;
    addr_t    fetch_addr;
    logic     cur_epoch;
    logic     data_valid;
    logic     data_ready;
    logic     data_we;
    addr_t    data_addr;
    word_t    data_wdata;
    logic     rsp_valid;
    bus_src_e rsp_src;
    logic     rsp_epoch;
    addr_t    rsp_pc;
    word_t    rsp_data;
    logic     fetch_slot_free;

    fetch_pc_unit #(
        .P_RESET_PC(P_RESET_PC)
    ) u_fetch_pc_unit (
        .clk          (clk),
        .rst          (rst),
        .i_redir_kind (i_redir_kind),
        .i_redir_pc   (i_redir_pc),
        .i_redir_base (i_redir_base),
        .i_redir_imm  (i_redir_imm),
        .i_fetch_ready(fetch_ready),
        .o_fetch_valid(fetch_valid),
        .o_fetch_addr (fetch_addr),
        .o_epoch      (cur_epoch)
    );

    lsu_req_buffer u_lsu_req_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_dreq_valid(i_dreq_valid),
        .i_dreq_we   (i_dreq_we),
        .i_dreq_addr (i_dreq_addr),
        .i_dreq_wdata(i_dreq_wdata),
        .i_out_ready (data_ready),
        .o_dreq_ready(o_dreq_ready),
        .o_out_valid (data_valid),
        .o_out_we    (data_we),
        .o_out_addr  (data_addr),
        .o_out_wdata (data_wdata)
    );

    mem_request_arbiter u_mem_request_arbiter (
        .clk              (clk),
        .rst              (rst),
        .i_fetch_valid    (fetch_valid),
        .i_fetch_addr     (fetch_addr),
        .i_fetch_epoch    (cur_epoch),
        .i_data_valid     (data_valid),
        .i_data_we        (data_we),
        .i_data_addr      (data_addr),
        .i_data_wdata     (data_wdata),
        .i_dreq_pending   (i_dreq_valid),
        .i_fetch_slot_free(fetch_slot_free),
        .i_bus_ready      (i_bus_ready),
        .i_bus_rvalid     (i_bus_rvalid),
        .i_bus_rdata      (i_bus_rdata),
        .o_fetch_ready    (fetch_ready),
        .o_data_ready     (data_ready),
        .o_bus_valid      (o_bus_valid),
        .o_bus_we         (o_bus_we),
        .o_bus_addr       (o_bus_addr),
        .o_bus_wdata      (o_bus_wdata),
        .o_rsp_valid      (rsp_valid),
        .o_rsp_src        (rsp_src),
        .o_rsp_epoch      (rsp_epoch),
        .o_rsp_pc         (rsp_pc),
        .o_rsp_data       (rsp_data),
        .o_freeze         (o_freeze)
    );

    bus_response_router u_bus_response_router (
        .clk              (clk),
        .rst              (rst),
        .i_rsp_valid      (rsp_valid),
        .i_rsp_src        (rsp_src),
        .i_rsp_epoch      (rsp_epoch),
        .i_rsp_pc         (rsp_pc),
        .i_rsp_data       (rsp_data),
        .i_cur_epoch      (cur_epoch),
        .i_instr_ready    (i_instr_ready),
        .o_fetch_slot_free(fetch_slot_free),
        .o_instr_valid    (o_instr_valid),
        .o_instr          (o_instr),
        .o_instr_pc       (o_instr_pc),
        .o_ld_valid       (o_ld_valid),
        .o_ld_data        (o_ld_data)
    );

endmodule

`default_nettype wire

//--- hw/bus_response_router.sv
`default_nettype none

module bus_response_router
    import core_types_pkg::*, mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     i_rsp_valid,
    input  wire bus_src_e i_rsp_src,
    input  wire logic     i_rsp_epoch,
    input  wire addr_t    i_rsp_pc,
    input  wire word_t    i_rsp_data,
    input  wire logic     i_cur_epoch,
    input  wire logic     i_instr_ready,
    output logic          o_fetch_slot_free,
    output logic          o_instr_valid,
    output instr_t        o_instr,
    output addr_t         o_instr_pc,
    output logic          o_ld_valid,
    output word_t         o_ld_data
);

    logic   slot_valid;
    logic   slot_epoch;
    logic   slot_live;
    instr_t slot_instr;
    addr_t  slot_pc;
    logic   take_instr;

    assign take_instr = i_rsp_valid && (i_rsp_src == FETCH) && (i_rsp_epoch == i_cur_epoch);

    // a redirect after capture makes the held instruction stale at once
    assign slot_live = slot_valid && (slot_epoch == i_cur_epoch);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_valid <= 1'b0;
            o_ld_valid <= 1'b0;
        end else begin
            o_ld_valid <= i_rsp_valid && (i_rsp_src == DATA);
            if (take_instr) begin
                slot_valid <= 1'b1;
            end else if (!slot_live || i_instr_ready) begin
                slot_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_instr) begin
            slot_epoch <= i_rsp_epoch;
            slot_instr <= i_rsp_data;
            slot_pc    <= i_rsp_pc;
        end
        if (i_rsp_valid && (i_rsp_src == DATA)) begin
            o_ld_data <= i_rsp_data;
        end
    end

    // only one access is outstanding, so a fetch granted here has the slot to itself
    assign o_fetch_slot_free = !slot_live || i_instr_ready;
    assign o_instr_valid     = slot_live;
    assign o_instr           = slot_instr;
    assign o_instr_pc        = slot_pc;

endmodule

`default_nettype wire

//--- hw/mem_request_arbiter.sv
`default_nettype none

module mem_request_arbiter
    import core_types_pkg::*, mem_bus_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  i_fetch_valid,
    input  wire addr_t i_fetch_addr,
    input  wire logic  i_fetch_epoch,
    input  wire logic  i_data_valid,
    input  wire logic  i_data_we,
    input  wire addr_t i_data_addr,
    input  wire word_t i_data_wdata,
    input  wire logic  i_dreq_pending,
    input  wire logic  i_fetch_slot_free,
    input  wire logic  i_bus_ready,
    input  wire logic  i_bus_rvalid,
    input  wire word_t i_bus_rdata,
    output logic       o_fetch_ready,
    output logic       o_data_ready,
    output logic       o_bus_valid,
    output logic       o_bus_we,
    output addr_t      o_bus_addr,
    output word_t      o_bus_wdata,
    output logic       o_rsp_valid,
    output bus_src_e   o_rsp_src,
    output logic       o_rsp_epoch,
    output addr_t      o_rsp_pc,
    output word_t      o_rsp_data,
    output logic       o_freeze
);

    arb_state_e state;
    arb_state_e state_nxt;
    bus_src_e   cur_src;
    logic       cur_epoch;
    logic       bus_we;
    addr_t      bus_addr;
    word_t      bus_wdata;
    logic       data_grant;
    logic       fetch_grant;
    logic       bus_done;
    logic       data_done_q;

    // data wins in IDLE, fetch waits for a free instruction slot
    assign o_data_ready  = (state == IDLE);
    assign o_fetch_ready = (state == IDLE) && !i_data_valid && i_fetch_slot_free;
    assign data_grant    = i_data_valid && o_data_ready;
    assign fetch_grant   = i_fetch_valid && o_fetch_ready;
    assign bus_done      = (state == WAIT_RESP) && i_bus_rvalid;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (data_grant || fetch_grant) begin
                    state_nxt = REQ;
                end
            end
            REQ: begin
                if (i_bus_ready) begin
                    state_nxt = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (i_bus_rvalid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            cur_src     <= FETCH;
            data_done_q <= 1'b0;
        end else begin
            state       <= state_nxt;
            data_done_q <= bus_done && (cur_src == DATA);
            if (data_grant) begin
                cur_src <= DATA;
            end else if (fetch_grant) begin
                cur_src <= FETCH;
            end
        end
    end

    // the fetch PC rides along in bus_addr until the response comes back
    always_ff @(posedge clk) begin
        if (data_grant) begin
            bus_we    <= i_data_we;
            bus_addr  <= i_data_addr;
            bus_wdata <= i_data_wdata;
        end else if (fetch_grant) begin
            bus_we    <= 1'b0;
            bus_addr  <= i_fetch_addr;
            bus_wdata <= '0;
            cur_epoch <= i_fetch_epoch;
        end
    end

    assign o_bus_valid = (state == REQ);
    assign o_bus_we    = bus_we;
    assign o_bus_addr  = bus_addr;
    assign o_bus_wdata = bus_wdata;

    // store responses end the access here and carry nothing onward
    assign o_rsp_valid = bus_done && !((cur_src == DATA) && bus_we);
    assign o_rsp_src   = cur_src;
    assign o_rsp_epoch = cur_epoch;
    assign o_rsp_pc    = bus_addr;
    assign o_rsp_data  = i_bus_rdata;

    // freeze also covers the cycle in which load data leaves the router
    assign o_freeze = i_dreq_pending || i_data_valid
        || ((state != IDLE) && (cur_src == DATA)) || data_done_q;

    // once the bus took a request, no new one may follow while it is outstanding
    a_no_req_in_wait: assert property (@(posedge clk) disable iff (rst)
        o_bus_valid && i_bus_ready |=> !o_bus_valid);

    a_rvalid_when_waiting: assert property (@(posedge clk) disable iff (rst)
        i_bus_rvalid |-> state == WAIT_RESP);

endmodule

`default_nettype wire

//--- hw/lsu_req_buffer.sv
`default_nettype none

module lsu_req_buffer
    import core_types_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  i_dreq_valid,
    input  wire logic  i_dreq_we,
    input  wire addr_t i_dreq_addr,
    input  wire word_t i_dreq_wdata,
    input  wire logic  i_out_ready,
    output logic       o_dreq_ready,
    output logic       o_out_valid,
    output logic       o_out_we,
    output addr_t      o_out_addr,
    output word_t      o_out_wdata
);

    logic  full;
    logic  req_we;
    addr_t req_addr;
    word_t req_wdata;

    // the entry is only refilled once it is empty, so take and give never overlap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (i_dreq_valid && o_dreq_ready) begin
            full <= 1'b1;
        end else if (o_out_valid && i_out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dreq_valid && o_dreq_ready) begin
            req_we    <= i_dreq_we;
            req_addr  <= i_dreq_addr;
            req_wdata <= i_dreq_wdata;
        end
    end

    assign o_dreq_ready = ~full;
    assign o_out_valid  = full;
    assign o_out_we     = req_we;
    assign o_out_addr   = req_addr;
    assign o_out_wdata  = req_wdata;

    a_held_stable: assert property (@(posedge clk) disable iff (rst)
        o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_we)
            && $stable(o_out_addr) && $stable(o_out_wdata));

endmodule

`default_nettype wire

//--- hw/fetch_pc_unit.sv
`default_nettype none

module fetch_pc_unit
    import core_types_pkg::*, mem_bus_pkg::*;
#(
    parameter addr_t P_RESET_PC = RESET_PC
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire redir_kind_e i_redir_kind,
    input  wire addr_t       i_redir_pc,
    input  wire addr_t       i_redir_base,
    input  wire addr_t       i_redir_imm,
    input  wire logic        i_fetch_ready,
    output logic             o_fetch_valid,
    output addr_t            o_fetch_addr,
    output logic             o_epoch
);

    addr_t pc;
    addr_t redir_target;
    addr_t jalr_sum;
    logic  epoch;
    logic  active;

    always_comb begin
        jalr_sum = i_redir_base + i_redir_imm;
        case (i_redir_kind)
            BRANCH, JAL: redir_target = i_redir_pc + i_redir_imm;
            // jalr drops the low bit of the sum, as the ISA asks
            JALR:        redir_target = {jalr_sum[31:1], 1'b0};
            default:     redir_target = pc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= P_RESET_PC;
            epoch  <= 1'b0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (i_redir_kind != NONE) begin
                // a fetch accepted on this same edge belongs to the old epoch
                pc    <= redir_target;
                epoch <= ~epoch;
            end else if (o_fetch_valid && i_fetch_ready) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign o_fetch_valid = active;
    assign o_fetch_addr  = pc;
    assign o_epoch       = epoch;

    a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        o_fetch_valid |-> o_fetch_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/mem_bus_pkg.sv
`default_nettype none

// enums shared by the blocks around the single memory bus
package mem_bus_pkg;

    // kind of control-flow change reported by the core for one cycle
    typedef enum logic [1:0] {
        NONE,
        BRANCH,
        JAL,
        JALR
    } redir_kind_e;

    // which requester owns the access on the bus
    typedef enum logic {
        FETCH,
        DATA
    } bus_src_e;

    // arbiter FSM, one access outstanding at most
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_RESP
    } arb_state_e;

endpackage

`default_nettype wire

//--- hw/core_types_pkg.sv
`default_nettype none

// basic word types of the core as seen by the memory request path
package core_types_pkg;

    // data word moved by loads and stores
    typedef logic [31:0] word_t;

    // byte address on the memory bus, always word aligned here
    typedef logic [31:0] addr_t;

    // raw instruction word handed to decode
    typedef logic [31:0] instr_t;

    // fetch starts here unless the top level overrides it
    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
